// ==== code_lock.f ====
+incdir+include
design/lock_pkg.sv
design/keypad_decoder.sv
design/lockout_timer.sv
design/lock_controller.sv
design/buzzer_sequencer.sv
design/code_lock_top.sv
dv/code_lock_chk.sv
dv/code_lock_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= code_lock_tb
FILELIST  ?= code_lock.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard design/*.sv dv/*.sv include/*.svh) $(FILELIST)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/code_lock_tb.sv ====
`include "lock_consts.svh"

module code_lock_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  digit_count;
    logic [1:0]  tries;
    logic        locked;
    logic        buzzer;

    lock_pkg::lock_state_e m_state;  // reference model of the lock
    logic [11:0]           m_entry;
    logic [1:0]            m_count;
    logic [1:0]            m_tries;

    // keypad bit per key id: digits 0-9, enter, clear-all, cancel, three unused bits
    int key_bit [16] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13, 0, 8, 12, 1, 2, 4};

    code_lock_top DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .onehot      (onehot),
        .display     (display),
        .digit_count (digit_count),
        .tries       (tries),
        .locked      (locked),
        .buzzer      (buzzer)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_display(input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            $display("Mismatch display: got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_count(input string name, input logic [1:0] got,
                                 input logic [1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_tone(input lock_pkg::tone_e got, input lock_pkg::tone_e exp);
        if (got !== exp) begin
            $display("Mismatch tone: got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    // tone named by the measured toggle spacing
    function automatic lock_pkg::tone_e tone_of_half(input int half);
        if (half == `LOCK_SUCCESS_HALF) return lock_pkg::SUCCESS;
        if (half == `LOCK_FAIL_HALF) return lock_pkg::FAIL;
        return lock_pkg::CLICK;
    endfunction

    task automatic wait_display(input logic [11:0] exp, input int limit);
        int n;
        n = 0;
        while (display !== exp) begin
            if (n == limit) begin
                $display("Timeout: display never reached %h, still %h", exp, display);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    // cycles until the buzzer next changes
    task automatic wait_toggle(output int cycles);
        logic last;
        last   = buzzer;
        cycles = 0;
        while (buzzer === last) begin
            if (cycles == 4 * `LOCK_FAIL_HALF) begin
                $display("Timeout: the buzzer stopped toggling");
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic update_model(input int id);
        if (id < 10 && m_state == lock_pkg::ENTRY && m_count < 2'd3) begin
            m_entry = {m_entry[7:0], 4'(id)};
            m_count = m_count + 2'd1;
        end else if (id == 10 && m_state == lock_pkg::ENTRY && m_count == 2'd3) begin
            if (m_entry == `LOCK_CODE) begin
                m_state = lock_pkg::PASS;
                m_entry = `LOCK_PASS_DISPLAY;
            end else begin
                m_entry = `LOCK_BLANK;
                m_count = 2'd0;
                if (m_tries == 2'(`LOCK_MAX_TRIES - 1)) begin
                    m_state = lock_pkg::LOCKOUT;
                    m_tries = 2'd0;
                end else begin
                    m_tries = m_tries + 2'd1;
                end
            end
        end else if (id == 11 || id == 12) begin
            m_state = lock_pkg::ENTRY;
            m_entry = `LOCK_BLANK;
            m_count = 2'd0;
            if (id == 11) m_tries = 2'd0;
        end
    endtask

    task automatic check_outputs();
        compare_display(display, (m_state == lock_pkg::LOCKOUT) ? 12'h000 : m_entry);
        compare_count("digit_count", digit_count, m_count);
        compare_count("tries", tries, m_tries);
        compare_flag("locked", locked, m_state == lock_pkg::LOCKOUT);
    endtask

    // entered at the second toggle, i.e. fail tone cycle 2 * half
    task automatic check_fail_gap();
        repeat (`LOCK_FAIL_GAP_START - 2 * `LOCK_FAIL_HALF) @(posedge clk);
        #1;
        for (int i = 0; i < `LOCK_FAIL_GAP_END - `LOCK_FAIL_GAP_START; i++) begin
            compare_flag("buzzer", buzzer, 1'b0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_lockout();
        int id;
        for (int s = 0; s <= `LOCK_LOCKOUT_SECS; s++) begin
            wait_display({4'h0, 4'(s / 10), 4'(s % 10)}, 2 * `LOCK_TICK_CYCLES);
            compare_flag("locked", locked, 1'b1);
            if (s == 2) begin
                id     = $urandom % 13;  // any real key, must be ignored
                onehot = 16'd1 << key_bit[id];
                repeat (2) @(posedge clk);
                #1 onehot = '0;
                compare_count("digit_count", digit_count, 2'd0);
                compare_count("tries", tries, 2'd0);
            end
        end
        wait_display(`LOCK_BLANK, 2 * `LOCK_TICK_CYCLES);
        m_state = lock_pkg::ENTRY;
        check_outputs();
    endtask

    task automatic press_key(input int id);
        logic            tone_key;
        logic            lock_key;
        lock_pkg::tone_e exp_tone;
        int              skip;
        int              half;
        tone_key = (id == 10) && (m_state == lock_pkg::ENTRY) && (m_count == 2'd3);
        exp_tone = (m_entry == `LOCK_CODE) ? lock_pkg::SUCCESS : lock_pkg::FAIL;
        lock_key = tone_key && (exp_tone == lock_pkg::FAIL) &&
                   (m_tries == 2'(`LOCK_MAX_TRIES - 1));
        update_model(id);
        onehot = 16'd1 << key_bit[id];
        if (tone_key) begin
            repeat (3) @(posedge clk);  // tone starts on the third edge
            #1 onehot = '0;
            wait_toggle(skip);
            wait_toggle(half);
            compare_tone(tone_of_half(half), exp_tone);
            if (exp_tone == lock_pkg::FAIL && !lock_key) check_fail_gap();
        end else begin
            repeat (1 + $urandom % 4) @(posedge clk);
            #1 onehot = '0;
            repeat (1 + $urandom % 3) @(posedge clk);
            #1;
        end
        check_outputs();
        if (lock_key) run_lockout();
    endtask

    task automatic try_code(input logic correct);
        press_key(12);
        press_key(correct ? 2 : $urandom % 10);
        press_key(correct ? 4 : $urandom % 10);
        press_key(correct ? 6 : (7 + $urandom % 9) % 10);  // never 6 when wrong
        press_key(10);
    endtask

    initial begin
        int r;
        void'($urandom(14));
        onehot  = '0;
        arst_n  = 1'b0;
        m_state = lock_pkg::ENTRY;
        m_entry = `LOCK_BLANK;
        m_count = 2'd0;
        m_tries = 2'd0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        check_outputs();
        compare_flag("buzzer", buzzer, 1'b0);
        try_code(1'b1);
        for (int i = 0; i < 120; i++) begin
            r = $urandom % 20;
            if (r < 3) try_code($urandom % 3 == 0);
            else if (r < 13) press_key(r - 3);  // digits
            else if (r < 15) press_key(10);
            else if (r == 15) press_key(11);
            else if (r < 18) press_key(12);
            else press_key(13 + $urandom % 3);  // unused bits
        end
        press_key(11);
        repeat (`LOCK_MAX_TRIES) try_code(1'b0);  // ends in a full lockout
        $display("No errors");
        $finish;
    end

endmodule

// ==== dv/code_lock_chk.sv ====
`include "lock_consts.svh"

module code_lock_chk (
    input logic        clk,
    input logic        arst_n,
    input logic        tone_start,
    input logic [11:0] display,
    input logic [1:0]  digit_count,
    input logic        locked,
    input logic        lockout_start,
    input logic        playing,
    input logic        buzzer
);
    timeunit 1ns;
    timeprecision 100ps;

    a_tone_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        tone_start |=> !tone_start)
        else $error("tone_start stayed high for two cycles");

    a_quiet_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !playing |-> !buzzer)
        else $error("buzzer high with no tone playing");

    // a count of three only drops to zero when the entry is blanked
    a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
        (digit_count == 2'd3) |=>
            (digit_count != 2'd0) || (display == `LOCK_BLANK) || locked)
        else $error("a fourth digit was counted");

    a_lock_entry: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(locked) |-> $past(lockout_start))
        else $error("locked rose without lockout_start");

endmodule

// one checker across the controller and the buzzer
bind code_lock_top code_lock_chk u_chk (
    .clk           (clk),
    .arst_n        (arst_n),
    .tone_start    (u_controller.tone_start),
    .display       (display),
    .digit_count   (digit_count),
    .locked        (locked),
    .lockout_start (u_controller.lockout_start),
    .playing       (u_buzzer.playing),
    .buzzer        (buzzer)
);

// ==== design/code_lock_top.sv ====
module code_lock_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [1:0]  tries,
    output logic        locked,
    output logic        buzzer
);

    logic            key_valid;
    lock_pkg::key_e  key;
    logic [3:0]      digit;
    logic            tone_start;
    lock_pkg::tone_e tone;
    logic            lockout_start;
    logic [7:0]      seconds;
    logic            lockout_done;

    keypad_decoder u_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key       (key),
        .digit     (digit)
    );

    lock_controller u_controller (
        .clk           (clk),
        .arst_n        (arst_n),
        .key_valid     (key_valid),
        .key           (key),
        .digit         (digit),
        .seconds       (seconds),
        .lockout_done  (lockout_done),
        .display       (display),
        .digit_count   (digit_count),
        .tries         (tries),
        .locked        (locked),
        .tone_start    (tone_start),
        .tone          (tone),
        .lockout_start (lockout_start)
    );

    lockout_timer u_timer (
        .clk           (clk),
        .arst_n        (arst_n),
        .lockout_start (lockout_start),
        .seconds       (seconds),
        .lockout_done  (lockout_done)
    );

    buzzer_sequencer u_buzzer (
        .clk        (clk),
        .arst_n     (arst_n),
        .tone_start (tone_start),
        .tone       (tone),
        .buzzer     (buzzer)
    );

endmodule

// ==== design/buzzer_sequencer.sv ====
`include "lock_consts.svh"

module buzzer_sequencer (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tone_start,
    input  lock_pkg::tone_e tone,
    output logic            buzzer
);

    lock_pkg::tone_e tone_q;
    logic            playing;
    logic            wave;      // square wave before the gap mask
    logic [15:0]     dur_cnt;
    logic [15:0]     half_cnt;
    logic [15:0]     half_lim;
    logic [15:0]     len_lim;
    logic            in_gap;

    always_comb begin
        case (tone_q)
            lock_pkg::CLICK: begin
                half_lim = 16'(`LOCK_CLICK_HALF);
                len_lim  = 16'(`LOCK_CLICK_LEN);
            end
            lock_pkg::SUCCESS: begin
                half_lim = 16'(`LOCK_SUCCESS_HALF);
                len_lim  = 16'(`LOCK_SUCCESS_LEN);
            end
            default: begin
                half_lim = 16'(`LOCK_FAIL_HALF);
                len_lim  = 16'(`LOCK_FAIL_LEN);
            end
        endcase
    end

    assign in_gap = (tone_q == lock_pkg::FAIL) &&
                    (dur_cnt >= 16'(`LOCK_FAIL_GAP_START)) &&
                    (dur_cnt < 16'(`LOCK_FAIL_GAP_END));
    assign buzzer = wave && !in_gap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tone_q   <= lock_pkg::CLICK;
            playing  <= 1'b0;
            wave     <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (tone_start) begin  // restarts any tone in progress
            tone_q   <= tone;
            playing  <= 1'b1;
            wave     <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (playing) begin
            if (dur_cnt == len_lim - 16'd1) begin
                playing <= 1'b0;
                wave    <= 1'b0;  // silent when idle
            end else begin
                dur_cnt <= dur_cnt + 16'd1;
                if (half_cnt == half_lim - 16'd1) begin
                    half_cnt <= '0;
                    wave     <= ~wave;
                end else begin
                    half_cnt <= half_cnt + 16'd1;
                end
            end
        end
    end

endmodule

// ==== design/lock_controller.sv ====
`include "lock_consts.svh"

module lock_controller (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              key_valid,
    input  lock_pkg::key_e    key,
    input  logic [3:0]        digit,
    input  logic [7:0]        seconds,
    input  logic              lockout_done,
    output logic [11:0]       display,
    output logic [1:0]        digit_count,
    output logic [1:0]        tries,
    output logic              locked,
    output logic              tone_start,
    output lock_pkg::tone_e   tone,
    output logic              lockout_start
);

    lock_pkg::lock_state_e state;
    logic [11:0]           entry;
    logic                  enter_full;
    logic                  code_match;
    logic                  last_try;

    assign enter_full = key_valid && (state == lock_pkg::ENTRY) &&
                        (key == lock_pkg::ENTER) && (digit_count == 2'd3);
    assign code_match = (entry == `LOCK_CODE);
    assign last_try   = (tries == 2'(`LOCK_MAX_TRIES - 1));

    // issued one cycle ahead of locked so the timer starts from 00
    assign lockout_start = enter_full && !code_match && last_try;

    assign display = (state == lock_pkg::LOCKOUT) ? {4'h0, seconds} : entry;
    assign locked  = (state == lock_pkg::LOCKOUT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= lock_pkg::ENTRY;
            entry       <= `LOCK_BLANK;
            digit_count <= 2'd0;
            tries       <= 2'd0;
            tone_start  <= 1'b0;
            tone        <= lock_pkg::CLICK;
        end else begin
            tone_start <= 1'b0;  // pulse by default
            if (state == lock_pkg::LOCKOUT) begin
                if (lockout_done) begin  // keys are ignored until here
                    state       <= lock_pkg::ENTRY;
                    entry       <= `LOCK_BLANK;
                    digit_count <= 2'd0;
                    tries       <= 2'd0;
                end
            end else if (key_valid) begin
                case (key)
                    lock_pkg::DIGIT: begin
                        if (state == lock_pkg::ENTRY && digit_count < 2'd3) begin
                            entry       <= {entry[7:0], digit};  // shift in from right
                            digit_count <= digit_count + 2'd1;
                            tone_start  <= 1'b1;
                            tone        <= lock_pkg::CLICK;
                        end
                    end
                    lock_pkg::ENTER: begin
                        if (enter_full) begin
                            tone_start <= 1'b1;
                            if (code_match) begin
                                state <= lock_pkg::PASS;
                                entry <= `LOCK_PASS_DISPLAY;  // count stays at 3
                                tone  <= lock_pkg::SUCCESS;
                            end else begin
                                entry       <= `LOCK_BLANK;
                                digit_count <= 2'd0;
                                tone        <= lock_pkg::FAIL;
                                if (lockout_start) begin
                                    state <= lock_pkg::LOCKOUT;
                                    tries <= 2'd0;
                                end else begin
                                    tries <= tries + 2'd1;
                                end
                            end
                        end
                    end
                    lock_pkg::CLEAR_ALL, lock_pkg::CANCEL: begin
                        state       <= lock_pkg::ENTRY;  // also leaves PASS
                        entry       <= `LOCK_BLANK;
                        digit_count <= 2'd0;
                        tone_start  <= 1'b1;
                        tone        <= lock_pkg::CLICK;
                        if (key == lock_pkg::CLEAR_ALL) begin
                            tries <= 2'd0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/lockout_timer.sv ====
`include "lock_consts.svh"

module lockout_timer (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       lockout_start,
    output logic [7:0] seconds,
    output logic       lockout_done
);

    localparam int DIV_W = $clog2(`LOCK_TICK_CYCLES);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`LOCK_TICK_CYCLES - 1);
    localparam logic [7:0] LAST_BCD = {4'(`LOCK_LOCKOUT_SECS / 10),
                                       4'(`LOCK_LOCKOUT_SECS % 10)};

    logic             running;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    assign tick         = running && (div_cnt == DIV_LAST);
    assign lockout_done = tick && (seconds == LAST_BCD);  // next tick would pass the end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            div_cnt <= '0;
            seconds <= '0;
        end else if (lockout_start) begin
            running <= 1'b1;
            div_cnt <= '0;
            seconds <= '0;
        end else if (running) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (lockout_done) begin
                running <= 1'b0;
                seconds <= '0;  // idle value is 00
            end else if (tick) begin
                if (seconds[3:0] == 4'd9) begin
                    seconds[7:4] <= seconds[7:4] + 4'd1;  // carry into tens
                    seconds[3:0] <= 4'd0;
                end else begin
                    seconds[3:0] <= seconds[3:0] + 4'd1;
                end
            end
        end
    end

endmodule

// ==== design/keypad_decoder.sv ====
module keypad_decoder (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [15:0]       onehot,
    output logic              key_valid,
    output lock_pkg::key_e    key,
    output logic [3:0]        digit
);

    logic [15:0]    prev_code;
    lock_pkg::key_e kind;
    logic [3:0]     value;

    // key map of the keypad; zero and multi-bit codes fall to default
    always_comb begin
        kind  = lock_pkg::DIGIT;
        value = 4'h0;
        case (onehot)
            16'h0001: kind  = lock_pkg::ENTER;
            16'h0008: value = 4'd0;
            16'h0020: value = 4'd3;
            16'h0040: value = 4'd2;
            16'h0080: value = 4'd1;
            16'h0100: kind  = lock_pkg::CLEAR_ALL;
            16'h0200: value = 4'd6;
            16'h0400: value = 4'd5;
            16'h0800: value = 4'd4;
            16'h1000: kind  = lock_pkg::CANCEL;
            16'h2000: value = 4'd9;
            16'h4000: value = 4'd8;
            16'h8000: value = 4'd7;
            default:  kind  = lock_pkg::NONE;  // unused bits too
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_code <= '0;
            key_valid <= 1'b0;
        end else begin
            prev_code <= onehot;  // updated for every code, even ignored ones
            key_valid <= (onehot != prev_code) && (kind != lock_pkg::NONE);
        end
    end

    always_ff @(posedge clk) begin
        key   <= kind;
        digit <= value;
    end

endmodule

// ==== design/lock_pkg.sv ====
package lock_pkg;

    // kind of key reported by the decoder
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        DIGIT     = 3'd1,
        ENTER     = 3'd2,
        CLEAR_ALL = 3'd3,
        CANCEL    = 3'd4
    } key_e;

    // controller states
    typedef enum logic [1:0] {
        ENTRY   = 2'd0,  // collecting digits
        PASS    = 2'd1,  // code accepted
        LOCKOUT = 2'd2   // too many wrong codes
    } lock_state_e;

    // tones the buzzer can play
    typedef enum logic [1:0] {
        CLICK   = 2'd0,  // key accepted
        SUCCESS = 2'd1,  // long high tone
        FAIL    = 2'd2   // lower broken tone
    } tone_e;

endpackage

// ==== include/lock_consts.svh ====
`ifndef LOCK_CONSTS_SVH
`define LOCK_CONSTS_SVH

// code and display patterns, BCD nibbles
`define LOCK_CODE            12'h246
`define LOCK_PASS_DISPLAY    12'hBCC  // shows "ASS" on the three positions
`define LOCK_BLANK           12'hFFF  // nibble F is a blank position

// tries and lockout
`define LOCK_MAX_TRIES       3
`define LOCK_LOCKOUT_SECS    8        // short for simulation
`define LOCK_TICK_CYCLES     20       // clock cycles per lockout second

// tone half periods in cycles
`define LOCK_CLICK_HALF      2
`define LOCK_SUCCESS_HALF    1
`define LOCK_FAIL_HALF       4

// tone durations in cycles
`define LOCK_CLICK_LEN       20
`define LOCK_SUCCESS_LEN     60
`define LOCK_FAIL_LEN        30
`define LOCK_FAIL_GAP_START  10       // silent window inside the fail tone
`define LOCK_FAIL_GAP_END    20

`endif
